// File: files.f
hw/fifo_pkg.sv
hw/fifo_mem_if.sv
hw/fifo_mem.sv
hw/gray_ptr_sync.sv
hw/fifo_write_ctrl.sv
hw/fifo_read_ctrl.sv
hw/async_fifo.sv
dv/async_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dual-clock FIFO testbench with Verilator
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=async_fifo_sim

verilator --binary --timing \
  -f files.f \
  --top-module async_fifo_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

echo "Simulation ended normally"
exit 0

// File: dv/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;

  import fifo_pkg::*;

  // Idle clock cycles allowed in any single wait
  localparam int WAIT_LIMIT = 200;

  // Words moved in the random traffic phase
  localparam int RANDOM_WORDS = 200;

  logic   wr_clk;
  logic   rd_clk;
  logic   reset;
  logic   wr_write;
  data_t  wr_data;
  logic   wr_full;
  logic   wr_prog_full;
  logic   rd_read;
  logic   rd_empty;
  data_t  rd_data;
  integer seed;

  // Expected words, oldest at the front
  data_t exp_q [$];

  async_fifo i_async_fifo (
    .wr_clk       (wr_clk),
    .rd_clk       (rd_clk),
    .reset        (reset),
    .wr_write     (wr_write),
    .wr_data      (wr_data),
    .wr_full      (wr_full),
    .wr_prog_full (wr_prog_full),
    .rd_read      (rd_read),
    .rd_empty     (rd_empty),
    .rd_data      (rd_data)
  );

  // Unrelated clocks, 20 ns and 34 ns
  always #10 wr_clk = ~wr_clk;
  always #17 rd_clk = ~rd_clk;

  // ####################################################################
  // Reference and compare
  // ####################################################################

  // Flag is a threshold, on at or above the level
  function automatic logic expected_prog_full(input level_t level);
    return (level >= level_t'(PROG_FULL_LEVEL));
  endfunction

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    abort_run();
  endtask

  task automatic check_data(input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t: rd_data is %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // ####################################################################
  // Write side, driven on wr_clk falling edges
  // ####################################################################

  // One word, held back while full
  task automatic write_word(input data_t word);
    int idle;
    idle = 0;
    @(negedge wr_clk);
    while (wr_full)
    begin
      idle++;
      if (idle > WAIT_LIMIT)
      begin
        report_timeout("room to write");
      end
      @(negedge wr_clk);
    end
    wr_data  = word;
    wr_write = 1'b1;
    exp_q.push_back(word);
    @(negedge wr_clk);
    wr_write = 1'b0;
  endtask

  // Random gaps and data, writes only while not full
  task automatic write_random(input int n);
    int done_cnt;
    int idle;
    done_cnt = 0;
    idle = 0;
    while (done_cnt < n)
    begin
      @(negedge wr_clk);
      wr_write = 1'b0;
      if (!wr_full && (($random(seed) & 1) != 0))
      begin
        wr_data  = $random(seed);
        wr_write = 1'b1;
        exp_q.push_back(wr_data);
        done_cnt++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > WAIT_LIMIT)
        begin
          report_timeout("the writer to make progress");
        end
      end
    end
    @(negedge wr_clk);
    wr_write = 1'b0;
  endtask

  task automatic wait_not_full();
    int idle;
    idle = 0;
    @(negedge wr_clk);
    while (wr_full)
    begin
      idle++;
      if (idle > WAIT_LIMIT)
      begin
        report_timeout("wr_full to clear");
      end
      @(negedge wr_clk);
    end
  endtask

  // ####################################################################
  // Read side, driven on rd_clk falling edges
  // ####################################################################

  // Fall-through data checked before the read strobe goes out
  // Optional stall on every third cycle
  task automatic read_words(input int n, input bit stall);
    int    got_cnt;
    int    idle;
    int    cyc;
    data_t exp_word;
    got_cnt = 0;
    idle = 0;
    cyc = 0;
    while (got_cnt < n)
    begin
      @(negedge rd_clk);
      rd_read = 1'b0;
      cyc++;
      if (!rd_empty && !(stall && (cyc % 3 == 0)))
      begin
        if (exp_q.size() == 0)
        begin
          $display("FIFO shows a word while none is expected");
          abort_run();
        end
        exp_word = exp_q.pop_front();
        check_data(rd_data, exp_word);
        rd_read = 1'b1;
        got_cnt++;
        idle = 0;
      end
      else
      begin
        idle++;
        if (idle > WAIT_LIMIT)
        begin
          report_timeout("data to read");
        end
      end
    end
    @(negedge rd_clk);
    rd_read = 1'b0;
  endtask

  task automatic wait_not_empty();
    int idle;
    idle = 0;
    @(negedge rd_clk);
    while (rd_empty)
    begin
      idle++;
      if (idle > WAIT_LIMIT)
      begin
        report_timeout("rd_empty to clear");
      end
      @(negedge rd_clk);
    end
  endtask

  // ####################################################################
  // Main sequence
  // ####################################################################

  initial
  begin
    seed     = 32'h5628_e8d0;
    wr_clk   = 1'b0;
    rd_clk   = 1'b0;
    reset    = 1'b1;
    wr_write = 1'b0;
    wr_data  = '0;
    rd_read  = 1'b0;

    repeat (10) @(negedge wr_clk);
    reset = 1'b0;

    // Reset state
    @(negedge wr_clk);
    check_flag(wr_full, 1'b0, "wr_full");
    check_flag(wr_prog_full, 1'b0, "wr_prog_full");
    check_flag(rd_empty, 1'b1, "rd_empty");

    // Random traffic in both domains at once
    fork
      write_random(RANDOM_WORDS);
      read_words(RANDOM_WORDS, 1'b1);
    join
    check_flag(rd_empty, 1'b1, "rd_empty");

    // Let the read pointer settle on the write side
    repeat (8) @(negedge wr_clk);

    // Ramp to full one word at a time, threshold checked per level
    for (int i = 1; i <= FIFO_DEPTH; i++)
    begin
      write_word($random(seed));
      repeat (4) @(negedge wr_clk);
      check_flag(wr_prog_full, expected_prog_full(level_t'(i)), "wr_prog_full");
    end
    check_flag(wr_full, 1'b1, "wr_full");

    // Overflow attempt, never enters the model
    wr_data  = 32'hdead_beef;
    wr_write = 1'b1;
    @(negedge wr_clk);
    wr_write = 1'b0;
    check_flag(wr_full, 1'b1, "wr_full");

    // Exactly the ramp words come back
    read_words(FIFO_DEPTH, 1'b0);
    check_flag(rd_empty, 1'b1, "rd_empty");
    repeat (8) @(negedge rd_clk);
    check_flag(rd_empty, 1'b1, "rd_empty");
    wait_not_full();
    repeat (4) @(negedge wr_clk);
    check_flag(wr_prog_full, expected_prog_full(level_t'(0)), "wr_prog_full");

    // Underflow attempt for a few cycles
    @(negedge rd_clk);
    rd_read = 1'b1;
    repeat (3) @(negedge rd_clk);
    rd_read = 1'b0;
    check_flag(rd_empty, 1'b1, "rd_empty");

    // A moved read pointer would show up as a huge level
    repeat (6) @(negedge wr_clk);
    check_flag(wr_full, 1'b0, "wr_full");
    check_flag(wr_prog_full, 1'b0, "wr_prog_full");

    // Next word passes through untouched
    write_word(32'h1234_abcd);
    wait_not_empty();
    read_words(1, 1'b0);
    check_flag(rd_empty, 1'b1, "rd_empty");

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  input  logic            wr_clk,
  input  logic            rd_clk,
  // Shared by both domains
  input  logic            reset,
  // Write side
  input  logic            wr_write,
  input  fifo_pkg::data_t wr_data,
  output logic            wr_full,
  output logic            wr_prog_full,
  // Read side
  input  logic            rd_read,
  output logic            rd_empty,
  output fifo_pkg::data_t rd_data
);

  import fifo_pkg::*;

  // ####################################################################
  // Crossing pointers
  // ####################################################################

  // Write pointer, source and rd_clk copy
  ptr_t wr_gray_ptr;
  ptr_t rd_wr_gray_ptr;

  // Read pointer, source and wr_clk copy
  ptr_t rd_gray_ptr;
  ptr_t wr_rd_gray_ptr;

  // Storage port bundle
  fifo_mem_if mem_if ();

  // Payload goes straight through the bundle
  assign mem_if.wr_data = wr_data;
  assign rd_data        = mem_if.rd_data;

  // ####################################################################
  // Blocks
  // ####################################################################

  fifo_write_ctrl i_fifo_write_ctrl (
    .wr_clk         (wr_clk),
    .reset          (reset),
    .wr_write       (wr_write),
    .wr_rd_gray_ptr (wr_rd_gray_ptr),
    .wr_gray_ptr    (wr_gray_ptr),
    .wr_full        (wr_full),
    .wr_prog_full   (wr_prog_full),
    .mem            (mem_if.writer)
  );

  fifo_mem i_fifo_mem (
    .wr_clk (wr_clk),
    .mem    (mem_if.mem)
  );

  fifo_read_ctrl i_fifo_read_ctrl (
    .rd_clk         (rd_clk),
    .reset          (reset),
    .rd_read        (rd_read),
    .rd_wr_gray_ptr (rd_wr_gray_ptr),
    .rd_gray_ptr    (rd_gray_ptr),
    .rd_empty       (rd_empty),
    .mem            (mem_if.reader)
  );

  // Write pointer into rd_clk for the empty flag
  gray_ptr_sync i_wr_ptr_sync (
    .clk     (rd_clk),
    .reset   (reset),
    .ptr_in  (wr_gray_ptr),
    .ptr_out (rd_wr_gray_ptr)
  );

  // Read pointer into wr_clk for the full flags
  gray_ptr_sync i_rd_ptr_sync (
    .clk     (wr_clk),
    .reset   (reset),
    .ptr_in  (rd_gray_ptr),
    .ptr_out (wr_rd_gray_ptr)
  );

endmodule

`default_nettype wire

// File: hw/fifo_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_read_ctrl (
  input  logic            rd_clk,
  input  logic            reset,
  input  logic            rd_read,
  // Write pointer already in rd_clk domain
  input  fifo_pkg::ptr_t  rd_wr_gray_ptr,
  // Toward the write domain synchronizer
  output fifo_pkg::ptr_t  rd_gray_ptr,
  output logic            rd_empty,
  fifo_mem_if.reader      mem
);

  import fifo_pkg::*;

  // ####################################################################
  // Local signals
  // ####################################################################

  ptr_t rd_bin_ptr;
  ptr_t rd_bin_next;
  ptr_t rd_gray_next;
  logic rd_accept;
  logic rd_empty_next;

  // ####################################################################
  // Pointer update
  // ####################################################################

  // Read is dropped while empty
  assign rd_accept = rd_read & ~rd_empty;

  // Advance by one on an accepted read
  assign rd_bin_next = rd_bin_ptr + {{FIFO_AW{1'b0}}, rd_accept};

  // Binary to Gray for crossing into wr_clk
  assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

  always_ff @(posedge rd_clk or posedge reset)
  begin
    if (reset)
    begin
      rd_bin_ptr  <= '0;
      rd_gray_ptr <= '0;
    end
    else
    begin
      rd_bin_ptr  <= rd_bin_next;
      rd_gray_ptr <= rd_gray_next;
    end
  end

  // Head of queue is always on the read port
  // Unclocked storage read gives fall-through behavior
  assign mem.rd_addr = rd_bin_ptr[FIFO_AW-1:0];

  // ####################################################################
  // Empty flag
  // ####################################################################

  // Pointers equal including wrap bit
  // Uses next pointer so flag rises on the edge taking the last word
  assign rd_empty_next = (rd_gray_next == rd_wr_gray_ptr);

  // Presets high, nothing stored yet
  always_ff @(posedge rd_clk or posedge reset)
  begin
    if (reset)
    begin
      rd_empty <= 1'b1;
    end
    else
    begin
      rd_empty <= rd_empty_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/fifo_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_write_ctrl (
  input  logic            wr_clk,
  input  logic            reset,
  input  logic            wr_write,
  // Read pointer already in wr_clk domain
  input  fifo_pkg::ptr_t  wr_rd_gray_ptr,
  // Toward the read domain synchronizer
  output fifo_pkg::ptr_t  wr_gray_ptr,
  output logic            wr_full,
  output logic            wr_prog_full,
  fifo_mem_if.writer      mem
);

  import fifo_pkg::*;

  // ####################################################################
  // Local signals
  // ####################################################################

  ptr_t   wr_bin_ptr;
  ptr_t   wr_bin_next;
  ptr_t   wr_gray_next;
  ptr_t   wr_rd_bin_ptr;
  level_t wr_level_next;
  logic   wr_accept;
  logic   wr_full_next;
  logic   wr_prog_full_next;

  // Gray back to binary, MSB first
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[FIFO_AW] = gray[FIFO_AW];
    for (int i = FIFO_AW - 1; i >= 0; i--)
    begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // ####################################################################
  // Pointer update
  // ####################################################################

  // Write is dropped while full
  assign wr_accept = wr_write & ~wr_full;

  // Advance by one on an accepted write
  assign wr_bin_next = wr_bin_ptr + {{FIFO_AW{1'b0}}, wr_accept};

  // Binary to Gray
  assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

  always_ff @(posedge wr_clk or posedge reset)
  begin
    if (reset)
    begin
      wr_bin_ptr  <= '0;
      wr_gray_ptr <= '0;
    end
    else
    begin
      wr_bin_ptr  <= wr_bin_next;
      wr_gray_ptr <= wr_gray_next;
    end
  end

  // Storage written at the current pointer, same edge as accept
  assign mem.wr_en   = wr_accept;
  assign mem.wr_addr = wr_bin_ptr[FIFO_AW-1:0];

  // ####################################################################
  // Flags
  // ####################################################################

  // Full in Gray terms
  // Top two bits inverted, remaining bits equal
  assign wr_full_next =
    (wr_gray_next[FIFO_AW:FIFO_AW-1] == ~wr_rd_gray_ptr[FIFO_AW:FIFO_AW-1]) &
    (wr_gray_next[FIFO_AW-2:0] == wr_rd_gray_ptr[FIFO_AW-2:0]);

  // Level from binary difference, wrap bit makes it exact up to DEPTH
  // Stale read pointer only ever overstates it
  assign wr_rd_bin_ptr     = gray_to_bin(wr_rd_gray_ptr);
  assign wr_level_next     = wr_bin_next - wr_rd_bin_ptr;
  assign wr_prog_full_next = (wr_level_next >= level_t'(PROG_FULL_LEVEL));

  always_ff @(posedge wr_clk or posedge reset)
  begin
    if (reset)
    begin
      wr_full      <= 1'b0;
      wr_prog_full <= 1'b0;
    end
    else
    begin
      wr_full      <= wr_full_next;
      wr_prog_full <= wr_prog_full_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/gray_ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync (
  // Destination clock
  input  logic           clk,
  input  logic           reset,
  // Gray pointer from the other domain
  input  fifo_pkg::ptr_t ptr_in,
  output fifo_pkg::ptr_t ptr_out
);

  import fifo_pkg::*;

  // First stage, may go metastable
  ptr_t sync_meta;

  // Two flops in series
  // Only one bit moves per source step, so a late sample is off by one at most
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sync_meta <= '0;
      ptr_out   <= '0;
    end
    else
    begin
      sync_meta <= ptr_in;
      ptr_out   <= sync_meta;
    end
  end

endmodule

`default_nettype wire

// File: hw/fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_mem (
  input  logic    wr_clk,
  fifo_mem_if.mem mem
);

  import fifo_pkg::*;

  // ####################################################################
  // Storage array
  // ####################################################################

  // FIFO_DEPTH words, contents undefined until written
  data_t mem_array [FIFO_DEPTH];

  // Write port
  // One word per wr_clk edge when enabled
  always_ff @(posedge wr_clk)
  begin
    if (mem.wr_en)
    begin
      mem_array[mem.wr_addr] <= mem.wr_data;
    end
  end

  // Read port
  // Asynchronous, follows rd_addr directly
  // Entry under rd_addr is stable once the read side sees it as non-empty
  assign mem.rd_data = mem_array[mem.rd_addr];

endmodule

`default_nettype wire

// File: hw/fifo_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_mem_if;

  import fifo_pkg::*;

  // Write port, all in wr_clk domain
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;

  // Read port, address from rd_clk domain
  addr_t rd_addr;
  data_t rd_data;

  // Write control owns the strobe and address
  modport writer (output wr_en, output wr_addr);

  // Read control only steers the read address
  modport reader (output rd_addr);

  // Storage side sees everything and returns read data
  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

// File: hw/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

  // ####################################################################
  // Geometry
  // ####################################################################

  // Address bits into the storage array
  localparam int FIFO_AW = 4;

  // Entries held, one per address
  localparam int FIFO_DEPTH = 16;

  // Bits per stored word
  localparam int FIFO_DW = 32;

  // Fill level where the early warning flag turns on
  localparam int PROG_FULL_LEVEL = 12;

  // ####################################################################
  // Vector types
  // ####################################################################

  // One FIFO word
  typedef logic [FIFO_DW-1:0] data_t;

  // Storage array index
  typedef logic [FIFO_AW-1:0] addr_t;

  // Pointer with an extra wrap bit on top
  // Holds either binary or Gray code
  typedef logic [FIFO_AW:0] ptr_t;

  // Fill count from empty up to FIFO_DEPTH inclusive
  typedef logic [FIFO_AW:0] level_t;

endpackage

`default_nettype wire
